// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - decoder.sv
  - execute.sv
  - retire.sv
  - rv_core.sv
  - target: test
    files:
      - tb_clock.sv
      - core_assertions.sv
      - tb_core.sv

// File: core_assertions.sv
// Core boundary assertions
`timescale 1ns/1ps
`default_nettype none

module core_assertions (
    input logic          clk,
    input logic          reset,
    input logic          instr_valid,
    input logic          instr_ready,
    input rv_pkg::word_t instr,
    input rv_pkg::tag_t  instr_tag,
    input logic          retire_valid
);
    int unsigned fail_count = 0;            // Seen by the testbench at the end
    logic        accept;

    assign accept = instr_valid && instr_ready;

    a_quiet_in_reset: assert property (@(posedge clk) !reset |-> !retire_valid)
        else begin
            $error("retire_valid high while reset is asserted");
            fail_count++;
        end

    // Accept edge plus two, sampled one edge later
    a_retire_after_accept: assert property (@(posedge clk) disable iff (!reset)
        accept |-> ##3 retire_valid)
        else begin
            $error("accepted instruction did not retire two cycles later");
            fail_count++;
        end

    a_retire_has_accept: assert property (@(posedge clk) disable iff (!reset)
        retire_valid |-> $past(accept, 3))
        else begin
            $error("retire_valid without a matching accept");
            fail_count++;
        end

    a_hold_while_stalled: assert property (@(posedge clk) disable iff (!reset)
        (instr_valid && !instr_ready) |=> instr_valid && $stable(instr) && $stable(instr_tag))
        else begin
            $error("instruction changed while stalled");
            fail_count++;
        end

endmodule

bind rv_core core_assertions u_core_assertions (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instr        (instr),
    .instr_tag    (instr_tag),
    .retire_valid (retire_valid)
);

`default_nettype wire

// File: decoder.sv
// Decode stage
// Operand select, register lock queue, bubbles
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     instr_pc,
    input  rv_pkg::tag_t      instr_tag,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output logic              dec_valid,
    output rv_pkg::xu_t       dec_xu,
    output rv_pkg::op_t       dec_op,
    output rv_pkg::word_t     dec_opa,
    output rv_pkg::word_t     dec_opb,
    output rv_pkg::reg_addr_t dec_rd,
    output logic              dec_we,
    output logic              dec_illegal,
    output rv_pkg::tag_t      dec_tag
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       is_auipc;
    logic       is_zero;
    logic       legal;
    logic       we_int;
    logic       accept;
    xu_t        xu;
    op_t        op;
    word_t      opa;
    word_t      opb;
    reg_mask_t  rd_mask;
    reg_mask_t  target;
    reg_mask_t  lock_mask;
    reg_mask_t  lock_queue [LOCK_DEPTH];

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign rd        = instr[11:7];
    assign rs1_addr  = instr[19:15];     // Straight to the register bank
    assign rs2_addr  = instr[24:20];

    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_zero   = (instr == '0);    // All-zero word taken as NOP

    assign imm_i = {{20{instr[31]}}, instr[31:20]};   // Sign-extended I immediate
    assign imm_u = {instr[31:12], 12'h000};

    // Legality, unit and operation
    always_comb begin
        xu    = XU_BYPASS;
        op    = OP_ADD;
        legal = 1'b0;
        if (is_op) begin
            legal = (funct7 == F7_BASE) ||
                    ((funct7 == F7_ALT) && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
        end else if (is_op_imm) begin
            case (funct3)
                F3_SLL:     legal = (funct7 == F7_BASE);
                F3_SRL_SRA: legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                default:    legal = 1'b1;
            endcase
        end else begin
            legal = is_lui || is_auipc || is_zero;
        end

        if (is_op || is_op_imm) begin
            case (funct3)
                F3_ADD_SUB: begin
                    xu = XU_ADDER;
                    op = (is_op && funct7 == F7_ALT) ? OP_SUB : OP_ADD;  // No SUBI
                end
                F3_SLT:     begin xu = XU_ADDER;   op = OP_SLT;  end
                F3_SLTU:    begin xu = XU_ADDER;   op = OP_SLTU; end
                F3_XOR:     begin xu = XU_LOGICAL; op = OP_XOR;  end
                F3_OR:      begin xu = XU_LOGICAL; op = OP_OR;   end
                F3_AND:     begin xu = XU_LOGICAL; op = OP_AND;  end
                F3_SLL:     begin xu = XU_SHIFTER; op = OP_SLL;  end
                default: begin                                   // SRL or SRA
                    xu = XU_SHIFTER;
                    op = (funct7 == F7_ALT) ? OP_SRA : OP_SRL;
                end
            endcase
        end else if (is_auipc) begin
            xu = XU_ADDER;                   // pc plus U immediate
            op = OP_ADD;
        end
    end

    // Operand select
    always_comb begin
        if (is_auipc)
            opa = instr_pc;
        else if (is_lui)
            opa = '0;
        else
            opa = rs1_data;

        if (is_op)
            opb = rs2_data;
        else if (is_lui || is_auipc)
            opb = imm_u;                     // LUI goes through bypass
        else
            opb = imm_i;                     // Also zero for the all-zero NOP
    end

    // Illegal words and x0 targets never write
    assign we_int  = legal && (rd != '0);
    assign rd_mask = we_int ? (reg_mask_t'(1) << rd) : '0;

    // Hazard check against pending writes
    always_comb begin
        lock_mask = '0;
        for (int i = 0; i < LOCK_DEPTH; i++)
            lock_mask = lock_mask | lock_queue[i];
    end

    assign instr_ready = !(lock_mask[rs1_addr] || lock_mask[rs2_addr]);
    assign accept      = instr_valid && instr_ready;
    assign target      = accept ? rd_mask : '0;   // Bubble pushes an empty mask

    // Register lock queue
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < LOCK_DEPTH; i++)
                lock_queue[i] <= '0;
        end else begin
            for (int i = 1; i < LOCK_DEPTH; i++)
                lock_queue[i] <= lock_queue[i-1];     // Age pending writes
            lock_queue[0] <= target;
        end
    end

    // Decode output registers, control part
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dec_valid   <= 1'b0;
            dec_we      <= 1'b0;
            dec_illegal <= 1'b0;
        end else begin
            dec_valid   <= accept;                    // Low means bubble
            dec_we      <= accept && we_int;
            dec_illegal <= accept && !legal;
        end
    end

    // Payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_xu  <= xu;
            dec_op  <= op;
            dec_opa <= opa;
            dec_opb <= opb;
            dec_rd  <= rd;
            dec_tag <= instr_tag;
        end
    end

endmodule

`default_nettype wire

// File: execute.sv
// Execute stage
// Adder, logical and shifter units
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic              clk,
    input  logic              reset,
    input  logic              dec_valid,
    input  rv_pkg::xu_t       dec_xu,
    input  rv_pkg::op_t       dec_op,
    input  rv_pkg::word_t     dec_opa,
    input  rv_pkg::word_t     dec_opb,
    input  rv_pkg::reg_addr_t dec_rd,
    input  logic              dec_we,
    input  logic              dec_illegal,
    input  rv_pkg::tag_t      dec_tag,
    output logic              ex_valid,
    output rv_pkg::word_t     ex_result,
    output rv_pkg::reg_addr_t ex_rd,
    output logic              ex_we,
    output logic              ex_illegal,
    output rv_pkg::tag_t      ex_tag
);
    import rv_pkg::*;

    word_t      adder_res;
    word_t      logic_res;
    word_t      shift_res;
    word_t      result;
    logic [4:0] shamt;

    assign shamt = dec_opb[4:0];            // Only low five bits shift

    always_comb begin
        case (dec_op)
            OP_ADD:  adder_res = dec_opa + dec_opb;
            OP_SUB:  adder_res = dec_opa - dec_opb;
            OP_SLT:  adder_res = {31'b0, $signed(dec_opa) < $signed(dec_opb)};
            OP_SLTU: adder_res = {31'b0, dec_opa < dec_opb};
            default: adder_res = '0;
        endcase

        case (dec_op)
            OP_XOR:  logic_res = dec_opa ^ dec_opb;
            OP_OR:   logic_res = dec_opa | dec_opb;
            OP_AND:  logic_res = dec_opa & dec_opb;
            default: logic_res = '0;
        endcase

        case (dec_op)
            OP_SLL:  shift_res = dec_opa << shamt;
            OP_SRL:  shift_res = dec_opa >> shamt;
            OP_SRA:  shift_res = word_t'($signed(dec_opa) >>> shamt);   // Sign fill
            default: shift_res = '0;
        endcase

        case (dec_xu)
            XU_ADDER:   result = adder_res;
            XU_LOGICAL: result = logic_res;
            XU_SHIFTER: result = shift_res;
            default:    result = dec_opb;   // Bypass, LUI value
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ex_valid   <= 1'b0;
            ex_we      <= 1'b0;
            ex_illegal <= 1'b0;
        end else begin
            ex_valid   <= dec_valid;
            ex_we      <= dec_valid && dec_we;
            ex_illegal <= dec_valid && dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_result <= result;
            ex_rd     <= dec_rd;
            ex_tag    <= dec_tag;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
rv_pkg.sv
decoder.sv
execute.sv
retire.sv
rv_core.sv
tb_clock.sv
core_assertions.sv
tb_core.sv

// File: retire.sv
// Retire stage
// Register bank and retire report
`timescale 1ns/1ps
`default_nettype none

module retire (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              ex_valid,
    input  rv_pkg::word_t     ex_result,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              ex_we,
    input  logic              ex_illegal,
    input  rv_pkg::tag_t      ex_tag,
    output logic              retire_valid,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data,
    output logic              retire_illegal,
    output rv_pkg::tag_t      retire_tag
);
    import rv_pkg::*;

    word_t bank [1:NUM_REGS-1];             // x0 has no storage

    // Asynchronous read ports, x0 reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : bank[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : bank[rs2_addr];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < NUM_REGS; i++)
                bank[i] <= '0;
        end else if (ex_valid && ex_we && ex_rd != '0) begin
            bank[ex_rd] <= ex_result;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            retire_valid   <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            retire_valid   <= ex_valid;     // Legal or not, every result reports
            retire_illegal <= ex_valid && ex_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire_rd   <= ex_rd;
            retire_data <= ex_illegal ? '0 : ex_result;
            retire_tag  <= ex_tag;
        end
    end

endmodule

`default_nettype wire

// File: rv_core.sv
// RV32I core slice top level
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     instr_pc,
    input  rv_pkg::tag_t      instr_tag,
    output logic              retire_valid,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data,
    output logic              retire_illegal,
    output rv_pkg::tag_t      retire_tag
);
    import rv_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    logic      dec_valid;                   // Decode to execute
    xu_t       dec_xu;
    op_t       dec_op;
    word_t     dec_opa;
    word_t     dec_opb;
    reg_addr_t dec_rd;
    logic      dec_we;
    logic      dec_illegal;
    tag_t      dec_tag;

    logic      ex_valid;                    // Execute to retire
    word_t     ex_result;
    reg_addr_t ex_rd;
    logic      ex_we;
    logic      ex_illegal;
    tag_t      ex_tag;

    decoder u_decoder (
        .clk, .reset,
        .instr_valid, .instr_ready, .instr, .instr_pc, .instr_tag,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .dec_valid, .dec_xu, .dec_op, .dec_opa, .dec_opb,
        .dec_rd, .dec_we, .dec_illegal, .dec_tag
    );

    execute u_execute (
        .clk, .reset,
        .dec_valid, .dec_xu, .dec_op, .dec_opa, .dec_opb,
        .dec_rd, .dec_we, .dec_illegal, .dec_tag,
        .ex_valid, .ex_result, .ex_rd, .ex_we, .ex_illegal, .ex_tag
    );

    retire u_retire (
        .clk, .reset,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_valid, .ex_result, .ex_rd, .ex_we, .ex_illegal, .ex_tag,
        .retire_valid, .retire_rd, .retire_data, .retire_illegal, .retire_tag
    );

endmodule

`default_nettype wire

// File: rv_pkg.sv
// RV32I core slice shared types
// Widths, unit and operation codes, opcodes
`default_nettype none

package rv_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;         // Data word and pc
    typedef logic [4:0]  reg_addr_t;     // Register index
    typedef logic [3:0]  tag_t;          // Instruction tag
    typedef logic [1:0]  xu_t;           // Execution unit select
    typedef logic [2:0]  op_t;           // Operation within a unit
    typedef logic [31:0] reg_mask_t;     // One-hot register mask

    // Execution units
    localparam xu_t XU_BYPASS  = 2'd0;   // Operand B straight through
    localparam xu_t XU_ADDER   = 2'd1;
    localparam xu_t XU_LOGICAL = 2'd2;
    localparam xu_t XU_SHIFTER = 2'd3;

    // Adder operations
    localparam op_t OP_ADD  = 3'd0;
    localparam op_t OP_SUB  = 3'd1;
    localparam op_t OP_SLTU = 3'd2;
    localparam op_t OP_SLT  = 3'd3;

    // Logical operations, same codes reused per unit
    localparam op_t OP_XOR = 3'd0;
    localparam op_t OP_OR  = 3'd1;
    localparam op_t OP_AND = 3'd2;

    // Shifter operations
    localparam op_t OP_SLL = 3'd0;
    localparam op_t OP_SRL = 3'd1;
    localparam op_t OP_SRA = 3'd2;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3 and funct7 fields of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;   // SUB and SRA

    // Pipeline
    localparam int LOCK_DEPTH = 2;       // Cycles a destination stays locked
    localparam int NUM_REGS   = 32;

endpackage

`default_nettype wire

// File: tb_clock.sv
// Testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);
    localparam int HALF_NS = 20;            // 40 ns period

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

// File: tb_core.sv
// Core slice testbench
// Random instructions against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import rv_pkg::*;

    localparam int NUM_INSTR = 400;
    localparam int RESET_CYC = 16;
    localparam int WDOG_NS   = (4 * NUM_INSTR + 100 + RESET_CYC) * 40;

    typedef struct {
        reg_addr_t rd;
        word_t     data;
        logic      illegal;
        tag_t      tag;
        int        cycle;                   // Negedge count when accepted
    } expect_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic        instr_ready;
    word_t       instr;
    word_t       instr_pc;
    tag_t        instr_tag;
    logic        retire_valid;
    reg_addr_t   retire_rd;
    word_t       retire_data;
    logic        retire_illegal;
    tag_t        retire_tag;

    logic [31:0] lcg_state = 32'h6e30_be5b;
    word_t       model_regs [32];           // Reference register file
    reg_mask_t   lock_q0 = '0;              // Destinations of the last two accepts
    reg_mask_t   lock_q1 = '0;
    expect_t     exp_q [$];
    int          cycle = 0;
    int          retired = 0;

    tb_clock u_tb_clock (.clk);

    rv_core u_rv_core (
        .clk, .reset,
        .instr_valid, .instr_ready, .instr, .instr_pc, .instr_tag,
        .retire_valid, .retire_rd, .retire_data, .retire_illegal, .retire_tag
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
            stop_on_error($sformatf("mismatch %s: got %h, expected %h", name, got, want));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};   // Weak low bits moved up
    endfunction

    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = lcg_next();
        return (r[4:2] != 3'd0) ? reg_addr_t'(r[1:0]) : reg_addr_t'(r[31:27]);  // Mostly x0..x3
    endfunction

    function automatic word_t make_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        r   = lcg_next();
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        f3  = r[10:8];
        f7  = (r[11] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        imm = r[31:20];
        if (r[3:0] < 4'd6) begin
            make_instr = {f7, rs2, rs1, f3, rd, OPC_OP};
        end else if (r[3:0] < 4'd10) begin
            if (f3 == 3'b001 || f3 == 3'b101)
                imm = {f7, r[16:12]};       // Shift amount forms
            make_instr = {imm, rs1, f3, rd, OPC_OP_IMM};
        end else if (r[3:0] < 4'd12) begin
            make_instr = {r[31:12], rd, OPC_LUI};
        end else if (r[3:0] == 4'd12) begin
            make_instr = {r[31:12], rd, OPC_AUIPC};
        end else if (r[3:0] == 4'd13) begin
            make_instr = r[12] ? 32'h0000_0000 : 32'h0000_0013;   // Both NOP forms
        end else if (r[3:0] == 4'd14) begin
            make_instr = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};  // MUL family
        end else begin
            make_instr = {imm, rs1, f3, rd, 7'b0000011};          // Load
        end
    endfunction

    // RV32I semantics for the kept subset
    function automatic void ref_exec(input word_t w, input word_t pc,
                                     output logic legal, output word_t val);
        word_t a;
        word_t b;
        logic  is_op;
        a     = model_regs[w[19:15]];
        is_op = (w[6:0] == OPC_OP);
        b     = is_op ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        legal = 1'b1;
        val   = '0;
        if (is_op || w[6:0] == OPC_OP_IMM) begin
            case (w[14:12])
                3'b000:  val = (is_op && w[30]) ? a - b : a + b;
                3'b001:  val = a << b[4:0];
                3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  val = (a < b) ? 32'd1 : 32'd0;
                3'b100:  val = a ^ b;
                3'b101:  val = w[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  val = a | b;
                default: val = a & b;
            endcase
            // Only SUB, SRA and SRAI may set bit 30 of funct7
            if (is_op || w[14:12] == 3'b001 || w[14:12] == 3'b101)
                legal = (w[31:25] == 7'b0000000) || (w[31:25] == 7'b0100000 &&
                        (w[14:12] == 3'b101 || (is_op && w[14:12] == 3'b000)));
        end else if (w[6:0] == OPC_LUI) begin
            val = {w[31:12], 12'h000};
        end else if (w[6:0] == OPC_AUIPC) begin
            val = pc + {w[31:12], 12'h000};
        end else begin
            legal = (w == '0);
        end
        if (!legal)
            val = '0;
    endfunction

    // Monitor, checks ready, retires and latency at the falling edge
    always @(negedge clk) begin : monitor
        reg_mask_t lock;
        logic      legal;
        word_t     val;
        expect_t   e;
        cycle++;
        if (u_rv_core.u_core_assertions.fail_count != 0)
            stop_on_error("an assertion in core_assertions failed");
        if (!reset) begin
            check_value("retire_valid", retire_valid, 32'd0);
        end else begin
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("retire_valid high with no instruction in flight");
                end else begin
                    e = exp_q.pop_front();
                    if (cycle != e.cycle + 3)
                        stop_on_error($sformatf("tag %h retired %0d cycles after accept",
                                                e.tag, cycle - e.cycle - 1));
                    check_value("retire_tag", retire_tag, e.tag);
                    check_value("retire_rd", retire_rd, e.rd);
                    check_value("retire_illegal", retire_illegal, e.illegal);
                    check_value("retire_data", retire_data, e.data);
                    retired++;
                end
            end
            lock = lock_q0 | lock_q1;
            check_value("instr_ready", instr_ready,
                        !(lock[instr[19:15]] || lock[instr[24:20]]));
            lock_q1 = lock_q0;              // Queue ages at the coming edge
            lock_q0 = '0;
            if (instr_valid && instr_ready) begin
                ref_exec(instr, instr_pc, legal, val);
                if (legal && instr[11:7] != 5'd0) begin
                    model_regs[instr[11:7]] = val;
                    lock_q0 = reg_mask_t'(1) << instr[11:7];
                end
                e.rd      = instr[11:7];
                e.data    = val;
                e.illegal = !legal;
                e.tag     = instr_tag;
                e.cycle   = cycle;
                exp_q.push_back(e);
            end
        end
    end

    // Stimulus
    initial begin
        logic [31:0] r;
        int          gap;
        foreach (model_regs[i])
            model_regs[i] = '0;
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        instr_tag   = '0;
        repeat (RESET_CYC) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            r   = lcg_next();
            gap = (r[2:0] == 3'd0) ? 1 + int'(r[3]) : 0;     // Occasional idle cycles
            repeat (gap) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= make_instr();
            instr_pc    <= 32'h0000_1000 + 32'(4 * i);
            instr_tag   <= tag_t'(i);
            do @(negedge clk); while (!instr_ready);         // Held until accepted
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);                           // Nothing extra may retire
        if (retired == NUM_INSTR && u_rv_core.u_core_assertions.fail_count == 0) begin
            $display("%0d instructions retired", retired);
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error($sformatf("retired %0d of %0d or an assertion failed",
                                    retired, NUM_INSTR));
        end
    end

    // Watchdog
    initial begin
        #(WDOG_NS);
        stop_on_error("watchdog expired, retirement stalled");
    end

endmodule

`default_nettype wire
